// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= coeffTokenDecoder.f
TB_TOP     ?= coeffTokenDecoderTb
RTL_TOP    ?= coeffTokenDecoder
BUILD_DIR  ?= obj_dir
BIN        ?= V$(TB_TOP)
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(BIN)
	./$(BUILD_DIR)/$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== coeffToken/chromaDcTable.sv ====
`timescale 1ns/100ps
`default_nettype none

module chromaDcTable
(
	input  wire cavlcTypesPkg::bitWindow_t  bitWindow,
	input  wire cavlcTypesPkg::headingPos_t headingPos,
	output cavlcTypesPkg::coeffToken_t      result
);

	cavlcTypesPkg::bitWindow_t suffix;

	// first bits after the leading one
	assign suffix = bitWindow << (5'(headingPos) + 5'd1);

	always_comb
	begin
		case (headingPos)
			4'd0: result = '{totalCoeff: 5'd1, trailingOnes: 2'd1, len: 5'd1};
			4'd1: result = '{totalCoeff: 5'd0, trailingOnes: 2'd0, len: 5'd2};
			4'd2: result = '{totalCoeff: 5'd2, trailingOnes: 2'd2, len: 5'd3};
			4'd3:
			begin
				result.len = 5'd6;
				case (suffix[15:14])
					2'b11:   {result.totalCoeff, result.trailingOnes} = {5'd1, 2'd0};
					2'b10:   {result.totalCoeff, result.trailingOnes} = {5'd2, 2'd1};
					2'b01:   {result.totalCoeff, result.trailingOnes} = {5'd3, 2'd3};
					default: {result.totalCoeff, result.trailingOnes} = {5'd2, 2'd0};
				endcase
			end
			4'd4:
			begin
				result.len          = 5'd6;
				result.totalCoeff   = suffix[15] ? 5'd3 : 5'd4;
				result.trailingOnes = 2'd0;
			end
			4'd5:
			begin
				result.len          = 5'd7;
				result.totalCoeff   = 5'd3;
				result.trailingOnes = suffix[15] ? 2'd1 : 2'd2;
			end
			4'd6:
			begin
				result.len          = 5'd8;
				result.totalCoeff   = 5'd4;
				result.trailingOnes = suffix[15] ? 2'd1 : 2'd2;
			end
			// 0000000, whatever follows it
			default: result = '{totalCoeff: 5'd4, trailingOnes: 2'd3, len: 5'd7};
		endcase
	end

endmodule

`default_nettype wire

// ==== coeffToken/coeffTokenDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenDecoder
(
	input  wire                             clk,
	input  wire                             reset_n,
	input  wire                             lookup,
	input  wire cavlcTypesPkg::nC_t         nC,
	input  wire cavlcTypesPkg::bitWindow_t  bitWindow,
	output cavlcTypesPkg::coeffToken_t      token
);

	cavlcTypesPkg::headingPos_t headingPos;
	cavlcTablePkg::nCClass_t    nCClass;
	cavlcTypesPkg::coeffToken_t lowResult;
	cavlcTypesPkg::coeffToken_t chromaResult;

	tokenPrefixScan tokenPrefixScan_i (
		.bitWindow  (bitWindow),
		.nC         (nC),
		.headingPos (headingPos),
		.nCClass    (nCClass)
	);

	// both tables decode every window, selection happens later
	lowNcTable lowNcTable_i (
		.bitWindow  (bitWindow),
		.headingPos (headingPos),
		.result     (lowResult)
	);

	chromaDcTable chromaDcTable_i (
		.bitWindow  (bitWindow),
		.headingPos (headingPos),
		.result     (chromaResult)
	);

	coeffTokenSelect coeffTokenSelect_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.lookup       (lookup),
		.nCClass      (nCClass),
		.bitWindow    (bitWindow),
		.headingPos   (headingPos),
		.lowResult    (lowResult),
		.chromaResult (chromaResult),
		.token        (token)
	);

endmodule

`default_nettype wire

// ==== coeffToken/coeffTokenSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenSelect
(
	input  wire                              clk,
	input  wire                              reset_n,
	input  wire                              lookup,
	input  wire cavlcTablePkg::nCClass_t     nCClass,
	input  wire cavlcTypesPkg::bitWindow_t   bitWindow,
	input  wire cavlcTypesPkg::headingPos_t  headingPos,
	input  wire cavlcTypesPkg::coeffToken_t  lowResult,
	input  wire cavlcTypesPkg::coeffToken_t  chromaResult,
	output cavlcTypesPkg::coeffToken_t       token
);

	cavlcTypesPkg::coeffToken_t   flcResult;
	cavlcTypesPkg::coeffToken_t   picked;
	cavlcTypesPkg::totalCoeff_t   heldTotal;
	cavlcTypesPkg::trailingOnes_t heldOnes;
	logic                         supported;

	assign supported = lookup && (nCClass != cavlcTablePkg::CLASS_NONE);

	// xxxxyy carries TotalCoeff-1 and TrailingOnes directly
	always_comb
	begin
		if (headingPos == cavlcTablePkg::FLC_ZERO_POS)
		begin
			flcResult.totalCoeff   = '0;
			flcResult.trailingOnes = '0;
		end
		else
		begin
			flcResult.totalCoeff   = 5'(bitWindow[15:12]) + 5'd1;
			flcResult.trailingOnes = bitWindow[11:10];
		end
		flcResult.len = cavlcTablePkg::FLC_LEN;
	end

	always_comb
	begin
		case (nCClass)
			cavlcTablePkg::CLASS_LOW:    picked = lowResult;
			cavlcTablePkg::CLASS_CHROMA: picked = chromaResult;
			default:                     picked = flcResult;
		endcase
	end

	// outside a lookup the last pair stays visible, len 0
	always_comb
	begin
		if (supported)
			token = picked;
		else
			token = '{totalCoeff: heldTotal, trailingOnes: heldOnes, len: 5'd0};
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			heldTotal <= '0;
			heldOnes  <= '0;
		end
		else if (supported)
		begin
			heldTotal <= picked.totalCoeff;
			heldOnes  <= picked.trailingOnes;
		end
	end

endmodule

`default_nettype wire

// ==== coeffToken/lowNcTable.sv ====
`timescale 1ns/100ps
`default_nettype none

module lowNcTable
(
	input  wire cavlcTypesPkg::bitWindow_t  bitWindow,
	input  wire cavlcTypesPkg::headingPos_t headingPos,
	output cavlcTypesPkg::coeffToken_t      result
);

	cavlcTypesPkg::bitWindow_t suffix;
	cavlcTypesPkg::codeLen_t   pos;
	logic [1:0]                pair;
	logic [2:0]                triple;

	assign pos = 5'(headingPos);

	// bits after the leading one, moved up to bit 15
	assign suffix = bitWindow << (pos + 5'd1);
	assign pair   = suffix[15:14];
	assign triple = suffix[15:13];

	always_comb
	begin
		result = '0;
		if (headingPos <= 4'd2)
		begin
			// 1, 01, 001
			result.totalCoeff   = pos;
			result.trailingOnes = headingPos[1:0];
			result.len          = pos + 5'd1;
		end
		else if (headingPos <= 4'd4)
		begin
			if (suffix[15])
			begin
				// 00011 and 000011, all trailing ones
				result.totalCoeff   = pos;
				result.trailingOnes = 2'd3;
				result.len          = pos + 5'd2;
			end
			else
			begin
				result.len = pos + 5'd3;
				if (headingPos == 4'd3)
				begin
					result.totalCoeff   = suffix[14] ? 5'd1 : 5'd2;
					result.trailingOnes = suffix[14] ? 2'd0 : 2'd1;
				end
				else
				begin
					result.totalCoeff   = suffix[14] ? 5'd3 : 5'd5;
					result.trailingOnes = suffix[14] ? 2'd2 : 2'd3;
				end
			end
		end
		else if (headingPos <= 4'd8)
		begin
			// regular block, two suffix bits step both counts down
			result.trailingOnes = ~pair;
			result.totalCoeff   = (pair == 2'b00) ? pos + 5'd1 : pos - 5'(pair);
			result.len          = pos + 5'd3;
		end
		else if (headingPos <= 4'd10)
		begin
			result.len = pos + 5'd4;
			if (headingPos == 4'd9)
			begin
				result.trailingOnes = (triple == 3'b000) ? 2'd0 : ~suffix[14:13];
				case (triple)
					3'b001:         result.totalCoeff = 5'd9;
					3'b011, 3'b110: result.totalCoeff = 5'd7;
					3'b100:         result.totalCoeff = 5'd10;
					3'b111:         result.totalCoeff = 5'd6;
					default:        result.totalCoeff = 5'd8;
				endcase
			end
			else
			begin
				result.trailingOnes = ~suffix[14:13];
				case (triple)
					3'b000:         result.totalCoeff = 5'd12;
					3'b001, 3'b100: result.totalCoeff = 5'd11;
					3'b110, 3'b111: result.totalCoeff = 5'd9;
					default:        result.totalCoeff = 5'd10;
				endcase
			end
		end
		else
		begin
			case (headingPos)
				4'd11:
				begin
					result.len          = 5'd15;
					result.trailingOnes = ~suffix[14:13];
					case (triple)
						3'b000:         result.totalCoeff = 5'd14;
						3'b001, 3'b100: result.totalCoeff = 5'd13;
						3'b110, 3'b111: result.totalCoeff = 5'd11;
						default:        result.totalCoeff = 5'd12;
					endcase
				end
				4'd12:
				begin
					result.len          = 5'd16;
					result.trailingOnes = ~suffix[14:13];
					case (triple)
						3'b000:                 result.totalCoeff = 5'd16;
						3'b011, 3'b101, 3'b110: result.totalCoeff = 5'd14;
						3'b111:                 result.totalCoeff = 5'd13;
						default:                result.totalCoeff = 5'd15;
					endcase
				end
				4'd13:
				begin
					result.len          = 5'd16;
					result.trailingOnes = (pair == 2'b00) ? 2'd0 : ~pair;
					result.totalCoeff   = (pair == 2'b11) ? 5'd15 : 5'd16;
				end
				4'd14:
				begin
					// 000000000000001, the only 15-bit code this deep
					result.len          = 5'd15;
					result.trailingOnes = 2'd1;
					result.totalCoeff   = 5'd13;
				end
				default:
				begin
					// no valid codeword, nothing consumed
					result = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== coeffTokenDecoder.f ====
common/cavlcTypesPkg.sv
common/cavlcTablePkg.sv
design/tokenPrefixScan.sv
coeffToken/lowNcTable.sv
coeffToken/chromaDcTable.sv
coeffToken/coeffTokenSelect.sv
coeffToken/coeffTokenDecoder.sv
sim/coeffTokenDecoder_sva.sv
sim/coeffTokenDecoderTb.sv

// ==== common/cavlcTablePkg.sv ====
`default_nettype none

package cavlcTablePkg;

	// which coeff_token table the current nC selects
	typedef logic [1:0] nCClass_t;

	localparam nCClass_t CLASS_LOW    = 2'd0;
	localparam nCClass_t CLASS_CHROMA = 2'd1;
	localparam nCClass_t CLASS_FLC    = 2'd2;
	localparam nCClass_t CLASS_NONE   = 2'd3;

	// nC = -1 in five bits
	localparam cavlcTypesPkg::nC_t NC_CHROMA_DC = 5'd31;
	localparam cavlcTypesPkg::nC_t NC_FLC_MIN   = 5'd8;

	localparam cavlcTypesPkg::codeLen_t FLC_LEN = 5'd6;

	// 000011 is the only fixed-length code with its first one here
	localparam cavlcTypesPkg::headingPos_t FLC_ZERO_POS = 4'd4;

endpackage

`default_nettype wire

// ==== common/cavlcTypesPkg.sv ====
`default_nettype none

package cavlcTypesPkg;

	// look-ahead window, bit 15 is the next bit of the stream
	typedef logic [15:0] bitWindow_t;

	// number of zeros ahead of the first one in the window
	typedef logic [3:0] headingPos_t;

	// predicted coefficient count, 31 stands for -1
	typedef logic [4:0] nC_t;

	// 0 to 16
	typedef logic [4:0] totalCoeff_t;

	// 0 to 3
	typedef logic [1:0] trailingOnes_t;

	// codeword length, 0 means nothing consumed
	typedef logic [4:0] codeLen_t;

	typedef struct packed {
		totalCoeff_t   totalCoeff;
		trailingOnes_t trailingOnes;
		codeLen_t      len;
	} coeffToken_t;

endpackage

`default_nettype wire

// ==== design/tokenPrefixScan.sv ====
`timescale 1ns/100ps
`default_nettype none

module tokenPrefixScan
(
	input  wire cavlcTypesPkg::bitWindow_t  bitWindow,
	input  wire cavlcTypesPkg::nC_t         nC,
	output cavlcTypesPkg::headingPos_t      headingPos,
	output cavlcTablePkg::nCClass_t         nCClass
);

	// scan upwards so the highest set bit is the last to write
	always_comb
	begin
		headingPos = 4'd15;
		for (int i = 0; i < 16; i++)
		begin
			if (bitWindow[i])
				headingPos = cavlcTypesPkg::headingPos_t'(15 - i);
		end
	end

	// 2 to 7 belong to tables this decoder does not carry
	always_comb
	begin
		if (nC < 5'd2)
			nCClass = cavlcTablePkg::CLASS_LOW;
		else if (nC == cavlcTablePkg::NC_CHROMA_DC)
			nCClass = cavlcTablePkg::CLASS_CHROMA;
		else if (nC >= cavlcTablePkg::NC_FLC_MIN)
			nCClass = cavlcTablePkg::CLASS_FLC;
		else
			nCClass = cavlcTablePkg::CLASS_NONE;
	end

endmodule

`default_nettype wire

// ==== sim/coeffTokenCodes.hex ====
// columns: class, TotalCoeff, TrailingOnes, length, codeword left-aligned in 16 bits
// class 0 is the table for 0 <= nC < 2, class 1 the chroma DC table
0 00 0 01 8000
0 01 0 06 1400
0 01 1 02 4000
0 02 0 08 0700
0 02 1 06 1000
0 02 2 03 2000
0 03 0 09 0380
0 03 1 08 0600
0 03 2 07 0A00
0 03 3 05 1800
0 04 0 0A 01C0
0 04 1 09 0300
0 04 2 08 0500
0 04 3 06 0C00
0 05 0 0B 00E0
0 05 1 0A 0180
0 05 2 09 0280
0 05 3 07 0800
0 06 0 0D 0078
0 06 1 0B 00C0
0 06 2 0A 0140
0 06 3 08 0400
0 07 0 0D 0058
0 07 1 0D 0070
0 07 2 0B 00A0
0 07 3 09 0200
0 08 0 0D 0040
0 08 1 0D 0050
0 08 2 0D 0068
0 08 3 0A 0100
0 09 0 0E 003C
0 09 1 0E 0038
0 09 2 0D 0048
0 09 3 0B 0080
0 0A 0 0E 002C
0 0A 1 0E 0028
0 0A 2 0E 0034
0 0A 3 0D 0060
0 0B 0 0F 001E
0 0B 1 0F 001C
0 0B 2 0E 0024
0 0B 3 0E 0030
0 0C 0 0F 0016
0 0C 1 0F 0014
0 0C 2 0F 001A
0 0C 3 0E 0020
0 0D 0 10 000F
0 0D 1 0F 0002
0 0D 2 0F 0012
0 0D 3 0F 0018
0 0E 0 10 000B
0 0E 1 10 000E
0 0E 2 10 000D
0 0E 3 0F 0010
0 0F 0 10 0007
0 0F 1 10 000A
0 0F 2 10 0009
0 0F 3 10 000C
0 10 0 10 0004
0 10 1 10 0006
0 10 2 10 0005
0 10 3 10 0008
1 00 0 02 4000
1 01 0 06 1C00
1 01 1 01 8000
1 02 0 06 1000
1 02 1 06 1800
1 02 2 03 2000
1 03 0 06 0C00
1 03 1 07 0600
1 03 2 07 0400
1 03 3 06 1400
1 04 0 06 0800
1 04 1 08 0300
1 04 2 08 0200
1 04 3 07 0000

// ==== sim/coeffTokenDecoderTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenDecoderTb;

	localparam int ROWS         = 76;
	localparam int FIELDS       = 5;
	localparam int ROW_PASSES   = 4;
	localparam int FLC_RUNS     = 200;
	localparam int SETTLE_STEPS = 25;

	logic                       clk;
	logic                       reset_n;
	logic                       lookup;
	cavlcTypesPkg::nC_t         nC;
	cavlcTypesPkg::bitWindow_t  bitWindow;
	cavlcTypesPkg::coeffToken_t token;

	// class, TotalCoeff, TrailingOnes, length, codeword per row
	logic [15:0] codeMem [0:ROWS*FIELDS-1];

	// pair the decoder should show outside a lookup
	logic [4:0] heldTotal;
	logic [1:0] heldOnes;

	int errors;
	int checks;

	coeffTokenDecoder coeffTokenDecoder_i (
		.clk       (clk),
		.reset_n   (reset_n),
		.lookup    (lookup),
		.nC        (nC),
		.bitWindow (bitWindow),
		.token     (token)
	);

	always #4 clk = ~clk;

	function automatic cavlcTypesPkg::coeffToken_t makeToken(input logic [4:0] tc,
		input logic [1:0] t1, input logic [4:0] len);
		cavlcTypesPkg::coeffToken_t t;
		t.totalCoeff   = tc;
		t.trailingOnes = t1;
		t.len          = len;
		return t;
	endfunction

	// codeword stays on top with random bits below it
	function automatic cavlcTypesPkg::bitWindow_t fillWindow(input logic [15:0] code,
		input logic [15:0] len);
		logic [15:0] mask;
		mask = 16'hFFFF >> len;
		return code | (16'($urandom) & mask);
	endfunction

	function automatic logic codeTableValid();
		for (int row = 0; row < ROWS; row++)
		begin
			if (codeMem[row*FIELDS] > 16'd1 || codeMem[row*FIELDS+3] == 16'd0 ||
				codeMem[row*FIELDS+3] > 16'd16)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic compareToken(input string testName,
		input cavlcTypesPkg::coeffToken_t expected, input cavlcTypesPkg::coeffToken_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %s expected tc %0d t1 %0d len %0d actual tc %0d t1 %0d len %0d",
				testName, expected.totalCoeff, expected.trailingOnes, expected.len,
				actual.totalCoeff, actual.trailingOnes, actual.len);
		end
	endtask

	task automatic applyInputs(input logic doLookup, input cavlcTypesPkg::nC_t nCValue,
		input cavlcTypesPkg::bitWindow_t window);
		@(negedge clk);
		lookup    = doLookup;
		nC        = nCValue;
		bitWindow = window;
	endtask

	// poll within the low clock phase until len shows whether a lookup is active
	task automatic waitForToken(input logic active, input string testName);
		int steps;
		steps = 0;
		#1;
		while (((token.len != 5'd0) != active) && steps < SETTLE_STEPS)
		begin
			#0.1;
			steps++;
		end
		if ((token.len != 5'd0) != active)
		begin
			errors++;
			$display("%s: token length did not settle before the next clock edge", testName);
		end
	endtask

	task automatic checkLookup(input string testName, input cavlcTypesPkg::nC_t nCValue,
		input cavlcTypesPkg::bitWindow_t window, input cavlcTypesPkg::coeffToken_t expected);
		applyInputs(1'b1, nCValue, window);
		waitForToken(1'b1, testName);
		compareToken(testName, expected, token);
		heldTotal = expected.totalCoeff;
		heldOnes  = expected.trailingOnes;
	endtask

	// lookup low, or lookup high with an nC this decoder does not carry
	task automatic idleCycle(input string testName);
		logic                      doLookup;
		cavlcTypesPkg::nC_t        nCValue;
		cavlcTypesPkg::bitWindow_t window;
		doLookup = 1'($urandom_range(1, 0));
		if (doLookup)
			nCValue = 5'($urandom_range(7, 2));
		else
			nCValue = 5'($urandom_range(31, 0));
		window = 16'($urandom);
		applyInputs(doLookup, nCValue, window);
		waitForToken(1'b0, testName);
		compareToken(testName, makeToken(heldTotal, heldOnes, 5'd0), token);
	endtask

	initial
	begin
		string                      name;
		int                         base;
		logic [5:0]                 code;
		cavlcTypesPkg::nC_t         nCValue;
		cavlcTypesPkg::bitWindow_t  window;
		cavlcTypesPkg::coeffToken_t expected;
		void'($urandom(32'hcd85));
		clk       = 1'b0;
		reset_n   = 1'b0;
		lookup    = 1'b0;
		nC        = '0;
		bitWindow = '0;
		heldTotal = '0;
		heldOnes  = '0;
		errors    = 0;
		checks    = 0;
		for (int i = 0; i < ROWS*FIELDS; i++)
			codeMem[i] = 16'hF000 | 16'(i);
		$readmemh("sim/coeffTokenCodes.hex", codeMem);
		if (!codeTableValid())
		begin
			errors++;
			$display("code file sim/coeffTokenCodes.hex is missing or malformed");
		end
		repeat (3) @(negedge clk);
		reset_n = 1'b1;

		// nothing has been decoded yet, so the held pair is zero
		idleCycle("after reset");

		for (int pass = 0; pass < ROW_PASSES; pass++)
		begin
			for (int row = 0; row < ROWS; row++)
			begin
				base     = row * FIELDS;
				expected = makeToken(5'(codeMem[base+1]), 2'(codeMem[base+2]),
					5'(codeMem[base+3]));
				window   = fillWindow(codeMem[base+4], codeMem[base+3]);
				if (codeMem[base] == 16'd0)
				begin
					nCValue = 5'($urandom_range(1, 0));
					name    = $sformatf("low nC row %0d pass %0d", row, pass);
				end
				else
				begin
					nCValue = 5'd31;
					name    = $sformatf("chroma DC row %0d pass %0d", row, pass);
				end
				checkLookup(name, nCValue, window, expected);
				// idle stretches keep the held pair on show for several cycles
				if ($urandom_range(2, 0) == 0)
					repeat ($urandom_range(3, 1))
						idleCycle($sformatf("idle after %s", name));
			end
		end

		for (int run = 0; run < FLC_RUNS; run++)
		begin
			code = 6'($urandom);
			// codes with more trailing ones than coefficients are not legal
			while (code == 6'b000010 || code == 6'b000111)
				code = 6'($urandom);
			nCValue = 5'($urandom_range(30, 8));
			window  = {code, 10'($urandom)};
			if (code == 6'b000011)
				expected = makeToken(5'd0, 2'd0, 5'd6);
			else
				expected = makeToken(5'(code[5:2]) + 5'd1, code[1:0], 5'd6);
			name = $sformatf("fixed length run %0d", run);
			checkLookup(name, nCValue, window, expected);
			if ($urandom_range(2, 0) == 0)
				repeat ($urandom_range(3, 1))
					idleCycle($sformatf("idle after %s", name));
		end

		idleCycle("final idle");
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		#100000;
		$display("simulation did not finish within its time limit");
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/coeffTokenDecoder_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenDecoderSva
(
	input wire                             clk,
	input wire                             reset_n,
	input wire                             lookup,
	input wire cavlcTypesPkg::nC_t         nC,
	input wire cavlcTypesPkg::coeffToken_t token
);

	logic supportedNc;

	// 0, 1, -1 and the fixed-length range
	assign supportedNc = (nC < 5'd2) || (nC >= 5'd8);

	lenOnlyInLookup: assert property (@(posedge clk) disable iff (!reset_n)
		(token.len != 5'd0) |-> lookup)
		else $error("token length is nonzero without a lookup");

	holdStable: assert property (@(posedge clk) disable iff (!reset_n)
		(!lookup && $past(!lookup)) |-> $stable(token))
		else $error("held token changed between cycles without a lookup");

	onesWithinTotal: assert property (@(posedge clk) disable iff (!reset_n)
		(lookup && supportedNc) |-> (5'(token.trailingOnes) <= token.totalCoeff))
		else $error("TrailingOnes exceeds TotalCoeff during a lookup");

endmodule

bind coeffTokenDecoder coeffTokenDecoderSva coeffTokenDecoderSva_i (
	.clk     (clk),
	.reset_n (reset_n),
	.lookup  (lookup),
	.nC      (nC),
	.token   (token)
);

`default_nettype wire
